// ==== source/rv_pkg.sv ====
// RV64I core package.
// Widths, opcode and funct encodings, immediate extraction and the APB map.

package rv_pkg;

  // ##########################################################################
  // Widths and types
  // ##########################################################################
  localparam int XLEN = 64;                   // Register and data width.

  typedef logic [XLEN-1:0] xlen_t;            // Register, data and immediate value.
  typedef logic [31:0]     inst_t;            // One instruction word.
  typedef logic [4:0]      reg_id_t;          // Register index x0..x31.
  typedef logic [XLEN-1:0] pc_t;              // Byte address, always word aligned.

  // ##########################################################################
  // Encodings
  // ##########################################################################
  localparam logic [6:0]  OP_IMM     = 7'b0010011;  // Register-immediate ALU ops.
  localparam logic [6:0]  AUIPC      = 7'b0010111;  // Add upper immediate to pc.
  localparam logic [6:0]  JAL        = 7'b1101111;  // Jump and link.
  localparam logic [6:0]  STORE      = 7'b0100011;  // Stores.
  localparam logic [6:0]  SYSTEM     = 7'b1110011;  // Environment calls and breaks.
  localparam logic [2:0]  F3_ADDI    = 3'b000;
  localparam logic [2:0]  F3_SD      = 3'b011;      // Doubleword store.
  localparam logic [11:0] F12_EBREAK = 12'h001;

  // Immediates, each sign-extended to the full register width.
  function automatic xlen_t imm_i(inst_t i);
    return {{(XLEN-12){i[31]}}, i[31:20]};
  endfunction

  function automatic xlen_t imm_u(inst_t i);
    return {{(XLEN-32){i[31]}}, i[31:12], 12'b0};
  endfunction

  function automatic xlen_t imm_j(inst_t i);
    return {{(XLEN-21){i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
  endfunction

  function automatic xlen_t imm_s(inst_t i);
    return {{(XLEN-12){i[31]}}, i[31:25], i[11:7]};
  endfunction

  // ##########################################################################
  // APB address map
  // ##########################################################################
  localparam int unsigned APB_IMEM_BASE = 'h000;  // Instruction words, write only.
  localparam int unsigned APB_CTRL      = 'h400;  // Run bit and status flags.
  localparam int unsigned APB_PC        = 'h404;  // Pc of the halting instruction.
  localparam int unsigned APB_REG_BASE  = 'h800;  // Two words per register.
  localparam int unsigned APB_REG_SPAN  = 'h100;  // 32 registers of 8 bytes.

endpackage

// ==== source/apb_ctrl.sv ====
// APB slave of the core.
// Loads instruction memory, starts the core and reads back status, pc and registers.

`timescale 1ns/1ps

module apb_ctrl import rv_pkg::*; #(
  parameter int IMEM_DEPTH = 256,
  parameter int APB_AW     = 12
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [APB_AW-1:0]             paddr,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [31:0]                   pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr,
  output logic                          imem_we,
  output logic [$clog2(IMEM_DEPTH)-1:0] imem_waddr,
  output inst_t                         imem_wdata,
  output logic                          start,
  output logic                          running,
  output logic                          halted,
  output logic                          illegal,
  input  logic                          halt_req,
  input  pc_t                           halt_pc,
  input  logic                          halt_illegal,
  output reg_id_t                       rf_apb_addr,
  input  xlen_t                         rf_apb_data
);

  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  logic [APB_AW-1:0] imem_off;        // Offset into the instruction window.
  logic [APB_AW-1:0] reg_off;         // Offset into the register window.
  logic              aligned;
  logic              imem_hit, ctrl_hit, pc_hit, reg_hit;
  logic              access;          // Access phase of any transfer.
  logic              wr_en;
  logic [31:0]       halt_pc_q;       // Low word of the halting pc.

  assign access   = psel & penable;
  assign wr_en    = access & pwrite;
  assign aligned  = (paddr[1:0] == 2'b00);                          // Word accesses only.
  assign imem_off = paddr - APB_AW'(APB_IMEM_BASE);                 // Wraps below the base.
  assign reg_off  = paddr - APB_AW'(APB_REG_BASE);
  assign imem_hit = aligned & (imem_off < APB_AW'(IMEM_DEPTH * 4));
  assign ctrl_hit = (paddr == APB_AW'(APB_CTRL));
  assign pc_hit   = (paddr == APB_AW'(APB_PC));
  assign reg_hit  = aligned & (reg_off < APB_AW'(APB_REG_SPAN));

  // ##########################################################################
  // Strobes toward fetch and the register file
  // ##########################################################################
  assign imem_we     = wr_en & imem_hit & ~running;                 // Memory frozen while running.
  assign imem_waddr  = imem_off[IMEM_AW+1:2];
  assign imem_wdata  = pwdata;
  assign start       = wr_en & ctrl_hit & pwdata[0] & ~running;     // One cycle, pready is high.
  assign rf_apb_addr = reg_off[7:3];                                // Eight bytes per register.

  // The only wait-free slave in the system, so pready never drops.
  assign pready  = 1'b1;
  assign pslverr = access & ((pwrite & imem_hit & running) |        // Imem write while running.
                             (pwrite & (pc_hit | reg_hit)) |        // Read-only windows.
                             (~pwrite & imem_hit) |                 // Imem is write only.
                             ~(imem_hit | ctrl_hit | pc_hit | reg_hit));

  // Read mux. Status, halt pc, or one half of a register.
  always_comb begin
    prdata = '0;
    if (ctrl_hit) begin
      prdata = {29'b0, illegal, halted, running};
    end else if (pc_hit) begin
      prdata = halt_pc_q;
    end else if (reg_hit) begin
      prdata = reg_off[2] ? rf_apb_data[63:32] : rf_apb_data[31:0];
    end
  end

  // Run flags. Start wins, halt_req only comes from a running core.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      running   <= 1'b0;
      halted    <= 1'b0;
      illegal   <= 1'b0;
      halt_pc_q <= '0;
    end else if (start) begin
      running <= 1'b1;                                              // Halted state is cleared.
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else if (halt_req) begin
      running   <= 1'b0;
      halted    <= 1'b1;
      illegal   <= halt_illegal;
      halt_pc_q <= halt_pc[31:0];                                   // Host reads the low word.
    end
  end

endmodule

// ==== source/fetch_stage.sv ====
// Fetch stage.
// Owns the pc and the instruction memory and issues one word per cycle.

`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          imem_we,
  input  logic [$clog2(IMEM_DEPTH)-1:0] imem_waddr,
  input  inst_t                         imem_wdata,
  input  logic                          start,
  input  logic                          running,
  input  logic                          redirect_valid,
  input  pc_t                           redirect_pc,
  input  logic                          halt_req,
  output logic                          f_valid,
  output inst_t                         f_inst,
  output pc_t                           f_pc
);

  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  inst_t              imem [IMEM_DEPTH];   // Loaded over APB while idle.
  pc_t                pc;
  logic [IMEM_AW-1:0] pc_idx;

  assign pc_idx = pc[IMEM_AW+1:2];         // Word index, the pc is always aligned.

  // Memory write port and registered read, so f_inst arrives one cycle after pc.
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_waddr] <= imem_wdata;
    end
    f_inst <= imem[pc_idx];
    f_pc   <= pc;                          // Travels with the word it addressed.
  end

  // Pc and valid flag.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc      <= '0;
      f_valid <= 1'b0;
    end else if (start) begin
      pc      <= '0;                        // Program always begins at address 0.
      f_valid <= 1'b0;
    end else if (redirect_valid) begin
      pc      <= redirect_pc;               // Jal target.
      f_valid <= 1'b0;                      // Squash the word read this cycle.
    end else begin
      f_valid <= running & ~halt_req;       // Nothing issues past a halt.
      if (running) begin
        pc <= pc + pc_t'(4);
      end
    end
  end

endmodule

// ==== source/decoder.sv ====
// Instruction decoder.
// Recognizes addi, auipc, jal, sd and ebreak, picks the immediate, flags the rest.

`timescale 1ns/1ps

module decoder import rv_pkg::*; (
  input  inst_t   inst,
  output reg_id_t rd,
  output reg_id_t rs1,
  output reg_id_t rs2,
  output xlen_t   imm,
  output logic    need_imm,
  output logic    alu_add,
  output logic    is_ebreak,
  output logic    is_auipc,
  output logic    is_jal,
  output logic    is_store,
  output logic    inst_not_ipl
);

  // ##########################################################################
  // Field matches
  // ##########################################################################
  logic op_imm, op_auipc, op_jal, op_store, op_system;
  logic f3_addi, f3_sd, f12_ebreak;

  assign op_imm     = (inst[6:0] == OP_IMM);
  assign op_auipc   = (inst[6:0] == AUIPC);
  assign op_jal     = (inst[6:0] == JAL);
  assign op_store   = (inst[6:0] == STORE);
  assign op_system  = (inst[6:0] == SYSTEM);
  assign f3_addi    = (inst[14:12] == F3_ADDI);
  assign f3_sd      = (inst[14:12] == F3_SD);
  assign f12_ebreak = (inst[31:20] == F12_EBREAK);   // Rd and rs1 are not checked.

  // ##########################################################################
  // Instructions
  // ##########################################################################
  logic addi, auipc, jal, sd, ebreak;

  assign addi   = op_imm & f3_addi;                  // Other op-imm functs stay illegal.
  assign auipc  = op_auipc;
  assign jal    = op_jal;
  assign sd     = op_store & f3_sd;                  // Narrower stores are not supported.
  assign ebreak = op_system & f3_addi & f12_ebreak;  // System funct3 is also 000.

  // Immediate by format. Exactly one type is set for a legal word.
  logic i_type, u_type, j_type, s_type;

  assign i_type = addi;
  assign u_type = auipc;
  assign j_type = jal;
  assign s_type = sd;

  assign imm = ({$bits(xlen_t){i_type}} & imm_i(inst)) |
               ({$bits(xlen_t){u_type}} & imm_u(inst)) |
               ({$bits(xlen_t){j_type}} & imm_j(inst)) |
               ({$bits(xlen_t){s_type}} & imm_s(inst));

  // Register fields sit in the same place for every format.
  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // ##########################################################################
  // Control
  // ##########################################################################
  assign alu_add      = addi | auipc;                 // Adder result goes to rd.
  assign need_imm     = addi | auipc | sd;            // Adder takes imm instead of rs2.
  assign is_ebreak    = ebreak;
  assign is_auipc     = auipc;
  assign is_jal       = jal;
  assign is_store     = sd;
  assign inst_not_ipl = ~(addi | auipc | jal | sd | ebreak);

endmodule

// ==== source/exec_stage.sv ====
// Execute stage.
// Registers the fetched word, decodes it, runs the adder and writes back in one cycle.

`timescale 1ns/1ps

module exec_stage import rv_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    f_valid,
  input  inst_t   f_inst,
  input  pc_t     f_pc,
  output reg_id_t rs1_id,
  output reg_id_t rs2_id,
  input  xlen_t   rs1_data,
  input  xlen_t   rs2_data,
  output logic    rf_we,
  output reg_id_t rf_waddr,
  output xlen_t   rf_wdata,
  output logic    redirect_valid,
  output pc_t     redirect_pc,
  output logic    halt_req,
  output pc_t     halt_pc,
  output logic    halt_illegal,
  output logic    store_valid,
  output xlen_t   store_addr,
  output xlen_t   store_data
);

  logic    d_valid;
  inst_t   d_inst;
  pc_t     d_pc;
  xlen_t   imm, op_a, op_b, alu_res;
  logic    need_imm, alu_add, is_ebreak, is_auipc, is_jal, is_store, inst_not_ipl;

  // Decode register. A jal or halt in execute kills the word behind it.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= f_valid & ~redirect_valid & ~halt_req;
    end
  end

  always_ff @(posedge clk) begin
    d_inst <= f_inst;
    d_pc   <= f_pc;
  end

  decoder u_decoder (
    .inst         (d_inst),
    .rd           (rf_waddr),
    .rs1          (rs1_id),
    .rs2          (rs2_id),
    .imm          (imm),
    .need_imm     (need_imm),
    .alu_add      (alu_add),
    .is_ebreak    (is_ebreak),
    .is_auipc     (is_auipc),
    .is_jal       (is_jal),
    .is_store     (is_store),
    .inst_not_ipl (inst_not_ipl)
  );

  // One adder serves addi, auipc and the sd address.
  assign op_a    = is_auipc ? d_pc : rs1_data;
  assign op_b    = need_imm ? imm : rs2_data;
  assign alu_res = op_a + op_b;

  assign rf_we    = d_valid & (alu_add | is_jal);            // Ebreak and sd write nothing.
  assign rf_wdata = is_jal ? (d_pc + xlen_t'(4)) : alu_res;  // Link is the next pc.

  assign redirect_valid = d_valid & is_jal;
  assign redirect_pc    = d_pc + imm;                        // J-immediate, pc relative.

  assign halt_req     = d_valid & (is_ebreak | inst_not_ipl);
  assign halt_pc      = d_pc;
  assign halt_illegal = inst_not_ipl;

  assign store_valid = d_valid & is_store;                    // Single-cycle pulse.
  assign store_addr  = alu_res;
  assign store_data  = rs2_data;

endmodule

// ==== source/reg_file.sv ====
// Integer register file.
// x1..x31 with two execute read ports, one write port and one APB read port.

`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  reg_id_t rs1_id,
  input  reg_id_t rs2_id,
  output xlen_t   rs1_data,
  output xlen_t   rs2_data,
  input  logic    rf_we,
  input  reg_id_t rf_waddr,
  input  xlen_t   rf_wdata,
  input  reg_id_t rf_apb_addr,
  output xlen_t   rf_apb_data
);

  xlen_t regs [1:31];                      // X0 has no storage.

  // X0 reads as zero on every port.
  function automatic xlen_t rd_reg(reg_id_t id);
    return (id == '0) ? '0 : regs[id];
  endfunction

  assign rs1_data    = rd_reg(rs1_id);
  assign rs2_data    = rd_reg(rs2_id);
  assign rf_apb_data = rd_reg(rf_apb_addr);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we && rf_waddr != '0) begin
      regs[rf_waddr] <= rf_wdata;           // Writes to x0 are dropped.
    end
  end

endmodule

// ==== source/rv_core_top.sv ====
// RV64I core top level.
// APB slave beside a fetch, execute and register-file pipeline, with a store port.

`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; #(
  parameter int IMEM_DEPTH = 256,
  parameter int APB_AW     = 12
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [APB_AW-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              store_valid,
  output xlen_t             store_addr,
  output xlen_t             store_data,
  output logic              halted,
  output logic              illegal
);

  logic                          imem_we, start, running;
  logic [$clog2(IMEM_DEPTH)-1:0] imem_waddr;
  inst_t                         imem_wdata, f_inst;
  logic                          f_valid, redirect_valid, halt_req, halt_illegal, rf_we;
  pc_t                           f_pc, redirect_pc, halt_pc;
  reg_id_t                       rs1_id, rs2_id, rf_waddr, rf_apb_addr;
  xlen_t                         rs1_data, rs2_data, rf_wdata, rf_apb_data;

  apb_ctrl #(.IMEM_DEPTH(IMEM_DEPTH), .APB_AW(APB_AW)) u_apb_ctrl (
    .clk, .arst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr,
    .imem_we, .imem_waddr, .imem_wdata, .start, .running, .halted, .illegal,
    .halt_req, .halt_pc, .halt_illegal, .rf_apb_addr, .rf_apb_data
  );

  fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
    .clk, .arst_n, .imem_we, .imem_waddr, .imem_wdata, .start, .running,
    .redirect_valid, .redirect_pc, .halt_req, .f_valid, .f_inst, .f_pc
  );

  exec_stage u_exec (
    .clk, .arst_n, .f_valid, .f_inst, .f_pc,
    .rs1_id, .rs2_id, .rs1_data, .rs2_data, .rf_we, .rf_waddr, .rf_wdata,
    .redirect_valid, .redirect_pc, .halt_req, .halt_pc, .halt_illegal,
    .store_valid, .store_addr, .store_data
  );

  reg_file u_reg_file (
    .clk, .arst_n, .rs1_id, .rs2_id, .rs1_data, .rs2_data,
    .rf_we, .rf_waddr, .rf_wdata, .rf_apb_addr, .rf_apb_data
  );

endmodule

// ==== tb/rv_core_props.sv ====
// Bound assertions on the RV64I core.
// Halt, store port, x0 and APB ready rules.

`timescale 1ns/1ps

module rv_core_props import rv_pkg::*; (
  input logic    clk,
  input logic    arst_n,
  input logic    start,
  input logic    halted,
  input logic    store_valid,
  input logic    pready,
  input reg_id_t rs1_id,
  input xlen_t   rs1_data,
  input reg_id_t rf_apb_addr,
  input xlen_t   rf_apb_data
);

  // A halted core has nothing in flight, so no store can leave it.
  no_store_when_halted: assert property (@(posedge clk) disable iff (!arst_n)
    halted |-> !store_valid)
    else $error("Store pulse seen while the core is halted.");

  // Only a new start clears the halted flag.
  halted_until_start: assert property (@(posedge clk) disable iff (!arst_n)
    (halted && !start) |=> halted)
    else $error("Halted dropped without a start.");

  // X0 must read as zero on both ports, whatever was written to it.
  x0_zero_exec: assert property (@(posedge clk) disable iff (!arst_n)
    (rs1_id == '0) |-> (rs1_data == '0))
    else $error("X0 read back nonzero on the execute port.");

  x0_zero_apb: assert property (@(posedge clk) disable iff (!arst_n)
    (rf_apb_addr == '0) |-> (rf_apb_data == '0))
    else $error("X0 read back nonzero on the APB port.");

  pready_high: assert property (@(posedge clk) disable iff (!arst_n) pready)
    else $error("APB pready went low.");

endmodule

bind rv_core_top rv_core_props u_props (
  .clk(clk), .arst_n(arst_n), .start(start), .halted(halted), .store_valid(store_valid),
  .pready(pready), .rs1_id(rs1_id), .rs1_data(rs1_data), .rf_apb_addr(rf_apb_addr),
  .rf_apb_data(rf_apb_data)
);

// ==== tb/tb_rv_core.sv ====
// Testbench for the RV64I core.
// Loads each table program over APB, runs it to halt, then checks registers, stores and status.

`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

  localparam int          N_TESTS    = 6;
  localparam int          MAX_LEN    = 8;               // Longest program in words.
  localparam int          MAX_ST     = 4;               // Most stores in one program.
  localparam logic [11:0] PROBE_ADDR = 12'h3fc;         // Last imem word.
  localparam inst_t       EBREAK_W   = 32'h0010_0073;

  logic        clk, arst_n;
  logic [11:0] paddr;
  logic        psel, penable, pwrite;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr, store_valid, halted, illegal;
  xlen_t       store_addr, store_data;

  // ##########################################################################
  // Test table
  // ##########################################################################
  string       t_name [N_TESTS];
  inst_t       t_prog [N_TESTS][MAX_LEN];
  int          t_len  [N_TESTS];
  xlen_t       t_regs [N_TESTS][32];                    // Expected x0..x31 after halt.
  int          t_nst  [N_TESTS];
  xlen_t       t_st_a [N_TESTS][MAX_ST];
  xlen_t       t_st_d [N_TESTS][MAX_ST];
  logic        t_ill  [N_TESTS];
  logic [31:0] t_pc   [N_TESTS];                        // Pc of the halting instruction.

  xlen_t       st_addr_q [$];                           // Stores seen in the current run.
  xlen_t       st_data_q [$];
  int          n_checks, n_errors;
  string       cur_name;

  rv_core_top #(.IMEM_DEPTH(256), .APB_AW(12)) u_dut (
    .clk, .arst_n, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .store_valid, .store_addr, .store_data, .halted, .illegal
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                             // 40 ns period.
  end

  // Store port has no back-pressure, so every pulse is one record.
  always @(negedge clk) begin
    if (arst_n && store_valid) begin
      st_addr_q.push_back(store_addr);
      st_data_q.push_back(store_data);
    end
  end

  // ##########################################################################
  // Encoders and immediate rules
  // ##########################################################################
  function automatic inst_t enc_addi(input reg_id_t rd, input reg_id_t rs1,
                                     input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic inst_t enc_auipc(input reg_id_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0010111};
  endfunction

  function automatic inst_t enc_jal(input reg_id_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic inst_t enc_sd(input reg_id_t rs1, input reg_id_t rs2,
                                   input logic [11:0] off);
    return {off[11:5], rs2, rs1, 3'b011, off[4:0], 7'b0100011};
  endfunction

  function automatic xlen_t sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};                            // Sign bit is bit 11.
  endfunction

  function automatic xlen_t upper20(input logic [19:0] v);
    return {{32{v[19]}}, v, 12'b0};                     // U-immediate sits above bit 12.
  endfunction

  task automatic add_inst(input int t, input inst_t w);
    t_prog[t][t_len[t]] = w;
    t_len[t]++;
  endtask

  task automatic add_store(input int t, input xlen_t a, input xlen_t d);
    t_st_a[t][t_nst[t]] = a;
    t_st_d[t][t_nst[t]] = d;
    t_nst[t]++;
  endtask

  task automatic build_table();
    logic [11:0] r [10];
    logic [19:0] ua, ub;
    foreach (r[i]) r[i] = 12'($urandom());
    ua = 20'($urandom());
    ub = 20'($urandom());
    for (int t = 0; t < N_TESTS; t++) begin
      t_len[t] = 0;
      t_nst[t] = 0;
      t_ill[t] = 1'b0;
      for (int k = 0; k < 32; k++) t_regs[t][k] = '0;   // Reset value of every register.
    end
    t_name[0] = "addi chain";
    add_inst(0, enc_addi(5'd1, 5'd0, r[0]));
    add_inst(0, enc_addi(5'd2, 5'd1, r[1]));
    add_inst(0, enc_addi(5'd3, 5'd2, r[2]));
    add_inst(0, enc_addi(5'd0, 5'd3, r[3]));            // Result must vanish.
    add_inst(0, enc_addi(5'd4, 5'd0, r[4]));
    add_inst(0, EBREAK_W);
    t_regs[0][1] = sext12(r[0]);
    t_regs[0][2] = t_regs[0][1] + sext12(r[1]);
    t_regs[0][3] = t_regs[0][2] + sext12(r[2]);
    t_regs[0][4] = sext12(r[4]);
    t_pc[0] = 32'd20;
    t_name[1] = "auipc";
    add_inst(1, enc_auipc(5'd5, ua));
    add_inst(1, enc_auipc(5'd6, ub));
    add_inst(1, enc_addi(5'd7, 5'd5, r[5]));
    add_inst(1, EBREAK_W);
    t_regs[1][5] = upper20(ua);
    t_regs[1][6] = 64'd4 + upper20(ub);
    t_regs[1][7] = t_regs[1][5] + sext12(r[5]);
    t_pc[1] = 32'd12;
    t_name[2] = "jal";
    add_inst(2, enc_addi(5'd1, 5'd0, 12'd1));
    add_inst(2, enc_jal(5'd2, 21'd12));                 // Jumps to 16.
    add_inst(2, enc_addi(5'd3, 5'd0, 12'd7));           // Both shadow words are squashed.
    add_inst(2, enc_addi(5'd4, 5'd0, 12'd9));
    add_inst(2, enc_addi(5'd5, 5'd1, 12'd5));
    add_inst(2, enc_jal(5'd0, 21'd8));                  // Link to x0 is dropped.
    add_inst(2, enc_addi(5'd6, 5'd0, 12'd3));
    add_inst(2, EBREAK_W);
    t_regs[2][1] = 64'd1;
    t_regs[2][2] = 64'd8;
    t_regs[2][5] = 64'd6;
    t_pc[2] = 32'd28;
    t_name[3] = "sd";
    add_inst(3, enc_addi(5'd1, 5'd0, r[6]));
    add_inst(3, enc_addi(5'd2, 5'd0, r[7]));
    add_inst(3, enc_sd(5'd1, 5'd2, r[8]));
    add_inst(3, enc_sd(5'd2, 5'd1, r[9]));
    add_inst(3, enc_addi(5'd3, 5'd0, 12'hfff));
    add_inst(3, enc_sd(5'd0, 5'd3, 12'd0));
    add_inst(3, EBREAK_W);
    t_regs[3][1] = sext12(r[6]);
    t_regs[3][2] = sext12(r[7]);
    t_regs[3][3] = '1;
    add_store(3, t_regs[3][1] + sext12(r[8]), t_regs[3][2]);
    add_store(3, t_regs[3][2] + sext12(r[9]), t_regs[3][1]);
    add_store(3, '0, '1);
    t_pc[3] = 32'd24;
    t_name[4] = "ebreak";
    add_inst(4, enc_addi(5'd7, 5'd0, 12'd123));
    add_inst(4, EBREAK_W);
    add_inst(4, enc_addi(5'd8, 5'd0, 12'd1));           // Must never execute.
    t_regs[4][7] = 64'd123;
    t_pc[4] = 32'd4;
    t_name[5] = "unimplemented add";
    add_inst(5, enc_addi(5'd1, 5'd0, 12'd5));
    add_inst(5, {7'b0, 5'd1, 5'd1, 3'b000, 5'd2, 7'b0110011});
    add_inst(5, enc_addi(5'd3, 5'd0, 12'd1));
    t_regs[5][1] = 64'd5;
    t_ill[5] = 1'b1;
    t_pc[5] = 32'd4;
  endtask

  // ##########################################################################
  // APB, reset and checks
  // ##########################################################################
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;                                    // Setup phase.
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;                                    // Access phase of one cycle.
    @(negedge clk);
    check_eq("pready in access phase", 64'd1, xlen_t'(pready));
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    arst_n <= 1'b0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  task automatic check_eq(input string what, input xlen_t exp, input xlen_t act);
    n_checks++;
    assert (act === exp) else begin
      n_errors++;
      $display("Fail %s: %s expected %h actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic run_entry(input int t);
    logic [31:0] lo, hi;
    logic        err;
    cur_name = t_name[t];
    apply_reset();                                      // Registers start from zero.
    for (int i = 0; i < t_len[t]; i++) begin
      apb_xfer(1'b1, 12'(APB_IMEM_BASE + 4 * i), t_prog[t][i], lo, err);
      check_eq("pslverr on imem load", '0, xlen_t'(err));
    end
    st_addr_q.delete();
    st_data_q.delete();
    apb_xfer(1'b1, 12'(APB_CTRL), 32'h1, lo, err);
    apb_xfer(1'b1, PROBE_ADDR, 32'hffff_ffff, lo, err); // Core is still running here.
    check_eq("pslverr on imem write while running", 64'd1, xlen_t'(err));
    while (halted !== 1'b1) @(negedge clk);
    check_eq("illegal port", xlen_t'(t_ill[t]), xlen_t'(illegal));
    apb_xfer(1'b0, 12'(APB_CTRL), '0, lo, err);
    check_eq("status", xlen_t'({t_ill[t], 2'b10}), xlen_t'(lo));
    apb_xfer(1'b0, 12'(APB_PC), '0, lo, err);
    check_eq("halt pc", xlen_t'(t_pc[t]), xlen_t'(lo));
    for (int k = 0; k < 32; k++) begin
      apb_xfer(1'b0, 12'(APB_REG_BASE + 8 * k), '0, lo, err);
      apb_xfer(1'b0, 12'(APB_REG_BASE + 8 * k + 4), '0, hi, err);
      check_eq($sformatf("x%0d", k), t_regs[t][k], {hi, lo});
    end
    check_eq("store count", xlen_t'(t_nst[t]), xlen_t'(st_addr_q.size()));
    for (int s = 0; s < t_nst[t] && s < st_addr_q.size(); s++) begin
      check_eq($sformatf("store %0d address", s), t_st_a[t][s], st_addr_q[s]);
      check_eq($sformatf("store %0d data", s), t_st_d[t][s], st_data_q[s]);
    end
  endtask

  initial begin : main
    arst_n   = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    n_checks = 0;
    n_errors = 0;
    void'($urandom(32'hc09c_e86e));
    build_table();
    for (int t = 0; t < N_TESTS; t++) begin
      run_entry(t);
    end
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Limit grows with the total program length.
  initial begin : watchdog
    int limit;
    #1;
    limit = 20;
    for (int t = 0; t < N_TESTS; t++) begin
      limit += t_len[t];
    end
    limit *= 200;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired: the run did not finish within %0d cycles.", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== compile.f ====
source/rv_pkg.sv
source/apb_ctrl.sv
source/fetch_stage.sv
source/decoder.sv
source/exec_stage.sv
source/reg_file.sv
source/rv_core_top.sv
tb/rv_core_props.sv
tb/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# Builds the RV64I core testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_rv_core -f compile.f -o sim_rv_core

./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  echo "Simulation passed."
  exit 0
fi
echo "Simulation failed, see sim.log."
exit 1
